//--- src/mbus_fault_pkg.sv
/*
 * Shared types for the MBus ring clock fault injector.
 * fault_kind codes 6 and 7 are not listed and are taken as no fault.
 * count_width sets the width of the completed-injection counter.
 */

package mbus_fault_pkg;

	// fault selector, as driven on the fault_kind port
	typedef enum logic [2:0]
	{
		GLITCH           = 3'd0,
		MISS_EDGE        = 3'd1,
		GLITCH_AFTER_INT = 3'd2,
		MISS_AFTER_INT   = 3'd3,
		STUCK_LOW        = 3'd4,
		STUCK_HIGH       = 3'd5
	} fault_kind_e;

	// how the outgoing clock is overridden
	typedef enum logic [1:0]
	{
		FORCE_NONE = 2'd0,
		FORCE_OR   = 2'd1,
		FORCE_AND  = 2'd2
	} force_mode_e;

	// override command from the sequencer to the clock gate
	// level 0 under OR, or 1 under AND, leaves the clock untouched
	typedef struct packed
	{
		force_mode_e mode;
		logic        level;
	} force_ctl_t;

	// ring lines after synchronization into CLK_FAST
	typedef struct packed
	{
		logic clk;
		logic dat;
		logic clk_rise;
		logic clk_fall;
		logic dat_toggle;
	} line_sample_t;

	localparam int count_width = 8;

endpackage

//--- src/mbus_line_sync.sv
/*
 * Brings the ring clock and data into CLK_FAST.
 * Levels lag the pins by 2 cycles; edge strobes follow one cycle later.
 * A line that is high out of reset gives one rise or toggle strobe.
 */

module mbus_line_sync
(
	input  logic                       CLK_FAST,
	input  logic                       RESETn,
	input  logic                       clk_in,
	input  logic                       din,
	output mbus_fault_pkg::line_sample_t line
);

	// two-flop synchronizer stages
	logic clk_s1;
	logic clk_s2;
	logic dat_s1;
	logic dat_s2;

	// synchronized values one cycle back
	logic clk_d;
	logic dat_d;

	// registered edge strobes
	logic clk_rise_q;
	logic clk_fall_q;
	logic dat_toggle_q;

	always_ff @(posedge CLK_FAST or negedge RESETn)
	begin
		if (!RESETn)
		begin
			clk_s1       <= 1'b0;
			clk_s2       <= 1'b0;
			dat_s1       <= 1'b0;
			dat_s2       <= 1'b0;
			clk_d        <= 1'b0;
			dat_d        <= 1'b0;
			clk_rise_q   <= 1'b0;
			clk_fall_q   <= 1'b0;
			dat_toggle_q <= 1'b0;
		end
		else
		begin
			clk_s1       <= clk_in;
			clk_s2       <= clk_s1;
			dat_s1       <= din;
			dat_s2       <= dat_s1;
			clk_d        <= clk_s2;
			dat_d        <= dat_s2;
			// strobes high for exactly one cycle per change
			clk_rise_q   <= clk_s2 & ~clk_d;
			clk_fall_q   <= ~clk_s2 & clk_d;
			dat_toggle_q <= dat_s2 ^ dat_d;
		end
	end

	always_comb
	begin
		line.clk        = clk_s2;
		line.dat        = dat_s2;
		line.clk_rise   = clk_rise_q;
		line.clk_fall   = clk_fall_q;
		line.dat_toggle = dat_toggle_q;
	end

endmodule

//--- src/mbus_int_detect.sv
/*
 * Flags an MBus interrupt: int_toggles data toggles while clk is high.
 * The flag holds for int_hold cycles and clears itself.
 * Both parameters must be at least 1.
 */

module mbus_int_detect
#(
	parameter int int_toggles = 3,
	parameter int int_hold    = 64
)
(
	input  logic                        CLK_FAST,
	input  logic                        RESETn,
	input  mbus_fault_pkg::line_sample_t line,
	output logic                        int_flag
);

	localparam int tog_w  = $clog2(int_toggles + 1);
	localparam int hold_w = $clog2(int_hold + 1);

	localparam logic [tog_w-1:0]  tog_last  = tog_w'(int_toggles - 1);
	localparam logic [hold_w-1:0] hold_load = hold_w'(int_hold - 1);

	logic [tog_w-1:0]  tog_cnt;
	logic [hold_w-1:0] hold_cnt;

	// the int_toggles-th toggle inside one high phase
	logic hit;

	assign hit = line.clk & line.dat_toggle & (tog_cnt == tog_last) & ~line.clk_fall;

	// toggle counter, cleared at every clock fall
	always_ff @(posedge CLK_FAST or negedge RESETn)
	begin
		if (!RESETn)
			tog_cnt <= '0;
		else if (line.clk_fall)
			tog_cnt <= '0;
		else if (hit)
			// start over so a second burst retriggers
			tog_cnt <= '0;
		else if (line.clk & line.dat_toggle)
			tog_cnt <= tog_cnt + 1'b1;
	end

	// hold timer
	always_ff @(posedge CLK_FAST or negedge RESETn)
	begin
		if (!RESETn)
		begin
			int_flag <= 1'b0;
			hold_cnt <= '0;
		end
		else if (hit)
		begin
			// new detection restarts the hold
			int_flag <= 1'b1;
			hold_cnt <= hold_load;
		end
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		else
			int_flag <= 1'b0;
	end

endmodule

//--- src/mbus_fault_fsm.sv
/*
 * Fault sequencer: arms on inject_start, waits for a low clock phase,
 * counts glitch_delay cycles, then forces the clock until release.
 * glitch_delay and glitch_width must be at least 1.
 * Re-arming needs inject_start low for a cycle; kinds 6 and 7 do nothing.
 */

module mbus_fault_fsm
#(
	parameter int glitch_delay = 12,
	parameter int glitch_width = 4
)
(
	input  logic                                    CLK_FAST,
	input  logic                                    RESETn,
	input  logic                                    inject_start,
	input  mbus_fault_pkg::fault_kind_e              fault_kind,
	input  mbus_fault_pkg::line_sample_t             line,
	input  logic                                    int_flag,
	output mbus_fault_pkg::force_ctl_t               force_ctl,
	output logic                                    fault_active,
	output logic [mbus_fault_pkg::count_width-1:0]   inject_count
);

	import mbus_fault_pkg::*;

	localparam int cnt_max = (glitch_delay > glitch_width) ? glitch_delay : glitch_width;
	localparam int cnt_w   = $clog2(cnt_max + 1);

	typedef enum logic [2:0]
	{
		IDLE,
		ARM,
		DELAY,
		FORCE,
		DONE
	} state_e;

	state_e       state;
	fault_kind_e  kind_q;
	logic [cnt_w-1:0] cnt;
	logic         seen_rise;

	// decoded kind
	force_mode_e kind_mode;
	logic        need_int;
	logic        stuck;
	logic        rel;

	always_comb
	begin
		kind_mode = FORCE_NONE;
		need_int  = 1'b0;
		stuck     = 1'b0;
		case (kind_q)
			GLITCH:
				kind_mode = FORCE_OR;
			MISS_EDGE:
				kind_mode = FORCE_AND;
			GLITCH_AFTER_INT:
			begin
				kind_mode = FORCE_OR;
				need_int  = 1'b1;
			end
			MISS_AFTER_INT:
			begin
				kind_mode = FORCE_AND;
				need_int  = 1'b1;
			end
			STUCK_LOW:
			begin
				kind_mode = FORCE_AND;
				stuck     = 1'b1;
			end
			STUCK_HIGH:
			begin
				kind_mode = FORCE_OR;
				stuck     = 1'b1;
			end
			default:
				kind_mode = FORCE_NONE;
		endcase
	end

	// release condition per kind, only meaningful in FORCE
	always_comb
	begin
		if (stuck)
			rel = ~inject_start;
		else if (kind_mode == FORCE_OR)
			rel = (cnt == '0);
		else
			// missing edge: one whole high phase swallowed
			rel = seen_rise & line.clk_fall;
	end

	always_ff @(posedge CLK_FAST or negedge RESETn)
	begin
		if (!RESETn)
		begin
			state        <= IDLE;
			kind_q       <= GLITCH;
			cnt          <= '0;
			seen_rise    <= 1'b0;
			inject_count <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (inject_start)
					begin
						// later changes on fault_kind are ignored
						kind_q <= fault_kind;
						state  <= ARM;
					end
				end
				ARM:
				begin
					if (!inject_start)
						state <= IDLE;
					else if (kind_mode == FORCE_NONE)
						state <= DONE;
					else if (!line.clk && (!need_int || int_flag))
					begin
						cnt       <= cnt_w'(glitch_delay - 1);
						seen_rise <= 1'b0;
						state     <= DELAY;
					end
				end
				DELAY:
				begin
					if (cnt == '0)
					begin
						cnt   <= cnt_w'(glitch_width - 1);
						state <= FORCE;
					end
					else
						cnt <= cnt - 1'b1;
				end
				FORCE:
				begin
					if (rel)
					begin
						inject_count <= inject_count + 1'b1;
						state        <= stuck ? IDLE : DONE;
					end
					else
					begin
						if (cnt != '0)
							cnt <= cnt - 1'b1;
						if (line.clk_rise)
							seen_rise <= 1'b1;
					end
				end
				DONE:
				begin
					if (!inject_start)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// passive level during DELAY, active level in FORCE
	always_comb
	begin
		fault_active = (state == DELAY) || (state == FORCE);
		if (fault_active)
			force_ctl.mode = kind_mode;
		else
			force_ctl.mode = FORCE_NONE;
		if (state == FORCE)
			force_ctl.level = (kind_mode == FORCE_OR);
		else
			force_ctl.level = (kind_mode == FORCE_AND);
	end

endmodule

//--- src/mbus_clk_gate.sv
/*
 * Output side: overrides the raw ring clock from the force control.
 * Purely combinational; clk_out follows clk_in with no register delay.
 * Data is never touched.
 */

module mbus_clk_gate
(
	input  logic                      clk_in,
	input  logic                      din,
	input  mbus_fault_pkg::force_ctl_t force_ctl,
	output logic                      clk_out,
	output logic                      dout
);

	import mbus_fault_pkg::*;

	// decoded mode, one-hot
	logic sel_or;
	logic sel_and;

	always_comb
	begin
		sel_or  = 1'b0;
		sel_and = 1'b0;
		case (force_ctl.mode)
			FORCE_OR:
				sel_or = 1'b1;
			FORCE_AND:
				sel_and = 1'b1;
			// FORCE_NONE and unused codes pass the clock through
			default:
			begin
				sel_or  = 1'b0;
				sel_and = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		if (sel_or)
			// glitch or stuck high
			clk_out = clk_in | force_ctl.level;
		else if (sel_and)
			// missing edge or stuck low
			clk_out = clk_in & force_ctl.level;
		else
			clk_out = clk_in;
	end

	// data line straight through
	assign dout = din;

endmodule

//--- src/mbus_fault_top.sv
/*
 * Fault injector for one break in an MBus ring.
 * Clock faults need a clk_in low phase longer than
 * 3 + glitch_delay + glitch_width CLK_FAST cycles.
 */

module mbus_fault_top
#(
	parameter int glitch_delay = 12,
	parameter int glitch_width = 4,
	parameter int int_toggles  = 3,
	parameter int int_hold     = 64
)
(
	input  logic                                  CLK_FAST,
	input  logic                                  RESETn,
	input  logic                                  clk_in,
	input  logic                                  din,
	input  mbus_fault_pkg::fault_kind_e            fault_kind,
	input  logic                                  inject_start,
	output logic                                  clk_out,
	output logic                                  dout,
	output logic                                  fault_active,
	output logic [mbus_fault_pkg::count_width-1:0] inject_count
);

	import mbus_fault_pkg::*;

	line_sample_t line;
	force_ctl_t   force_ctl;
	logic         int_flag;

	// input side
	mbus_line_sync u_line_sync
	(
		.CLK_FAST (CLK_FAST),
		.RESETn   (RESETn),
		.clk_in   (clk_in),
		.din      (din),
		.line     (line)
	);

	mbus_int_detect
	#(
		.int_toggles (int_toggles),
		.int_hold    (int_hold)
	)
	u_int_detect
	(
		.CLK_FAST (CLK_FAST),
		.RESETn   (RESETn),
		.line     (line),
		.int_flag (int_flag)
	);

	mbus_fault_fsm
	#(
		.glitch_delay (glitch_delay),
		.glitch_width (glitch_width)
	)
	u_fault_fsm
	(
		.CLK_FAST     (CLK_FAST),
		.RESETn       (RESETn),
		.inject_start (inject_start),
		.fault_kind   (fault_kind),
		.line         (line),
		.int_flag     (int_flag),
		.force_ctl    (force_ctl),
		.fault_active (fault_active),
		.inject_count (inject_count)
	);

	// output side, raw clock in and out
	mbus_clk_gate u_clk_gate
	(
		.clk_in    (clk_in),
		.din       (din),
		.force_ctl (force_ctl),
		.clk_out   (clk_out),
		.dout      (dout)
	);

endmodule

//--- tb/mbus_fault_checker.sv
/*
 * Watches the injector ports on every rising CLK_FAST.
 * A window is the span with inject_start high, scored once the fault is released.
 * Data only changes in clk_in low phases, so toggles while high mean an interrupt.
 */

module mbus_fault_checker
#(
	parameter int int_toggles = 3
)
(
	input  logic                                  CLK_FAST,
	input  logic                                  RESETn,
	input  logic                                  clk_in,
	input  logic                                  din,
	input  mbus_fault_pkg::fault_kind_e            fault_kind,
	input  logic                                  inject_start,
	input  logic                                  clk_out,
	input  logic                                  dout,
	input  logic                                  fault_active,
	input  logic [mbus_fault_pkg::count_width-1:0] inject_count,
	output int                                    pass_count,
	output int                                    fail_count,
	output int                                    error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	import mbus_fault_pkg::*;

	// previous samples
	logic prev_clk_in;
	logic prev_clk_out;
	logic prev_din;
	logic prev_start;
	logic in_window;
	logic rst_checked;
	logic int_seen;

	fault_kind_e win_kind;

	// per-window edge counts
	int in_rises;
	int out_rises;
	int lone_rise;
	int lone_fall;
	int act_rises;
	int act_falls;
	int high_toggles;
	int exp_diff;
	int exp_count = 0;
	int test_no = 0;
	int err_at_open = 0;
	int passes = 0;
	int fails = 0;
	int errors = 0;

	// expected clk_out minus clk_in rising edges per window
	function automatic int expected_diff(input fault_kind_e kind, input logic had_int);
		case (kind)
			GLITCH:           return 1;
			MISS_EDGE:        return -1;
			GLITCH_AFTER_INT: return had_int ? 1 : 0;
			MISS_AFTER_INT:   return had_int ? -1 : 0;
			default:          return 0;
		endcase
	endfunction

	// whether the window ends with one more completed injection
	function automatic logic fault_completes(input fault_kind_e kind, input logic had_int);
		case (kind)
			GLITCH, MISS_EDGE, STUCK_LOW, STUCK_HIGH: return 1'b1;
			GLITCH_AFTER_INT, MISS_AFTER_INT:         return had_int;
			default:                                  return 1'b0;
		endcase
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0t %s", $time, msg);
	endtask

	task automatic score_window();
		int_seen = (high_toggles >= int_toggles);
		exp_diff = expected_diff(win_kind, int_seen);
		if (fault_completes(win_kind, int_seen))
			exp_count++;
		test_no++;
		if (win_kind == STUCK_LOW)
		begin
			if (act_rises != 0)
				report_error($sformatf("stuck low let %0d clk_out rises through", act_rises));
		end
		else if (win_kind == STUCK_HIGH)
		begin
			if (act_rises != 1 || act_falls != 0)
				report_error($sformatf("stuck high gave %0d rises, %0d falls", act_rises, act_falls));
		end
		else
		begin
			if (out_rises - in_rises != exp_diff)
				report_error($sformatf("edge difference %0d, expected %0d",
					out_rises - in_rises, exp_diff));
			// extra pulse must start and end while clk_in is low
			if (exp_diff == 1 && (lone_rise != 1 || lone_fall != 1))
				report_error("glitch pulse not inside a clk_in low phase");
			if (exp_diff != 1 && lone_rise != 0)
				report_error("unexpected clk_out pulse in a clk_in low phase");
		end
		if (inject_count !== count_width'(exp_count))
			report_error($sformatf("inject_count %0d, expected %0d", inject_count, exp_count));
		if (errors == err_at_open)
		begin
			passes++;
			$display("test %0d kind %0d int %0b: clk_in rises %0d clk_out rises %0d count %0d ok",
				test_no, win_kind, int_seen, in_rises, out_rises, inject_count);
		end
		else
		begin
			fails++;
			$display("test %0d kind %0d int %0b: failed", test_no, win_kind, int_seen);
		end
	endtask

	always @(posedge CLK_FAST)
	begin
		if (!RESETn)
		begin
			rst_checked = 1'b0;
			in_window   = 1'b0;
		end
		else
		begin
			if (!rst_checked)
			begin
				rst_checked = 1'b1;
				if (fault_active !== 1'b0 || inject_count !== '0)
					report_error("fault_active or inject_count not cleared after reset");
			end
			// data is never touched
			if (dout !== din)
				report_error($sformatf("dout %b differs from din %b", dout, din));
			// no fault active means pure pass-through
			if (!fault_active && clk_out !== clk_in)
				report_error($sformatf("clk_out %b differs from clk_in %b", clk_out, clk_in));
			if (inject_start && !prev_start && !in_window)
			begin
				in_window    = 1'b1;
				win_kind     = fault_kind;
				in_rises     = 0;
				out_rises    = 0;
				lone_rise    = 0;
				lone_fall    = 0;
				act_rises    = 0;
				act_falls    = 0;
				high_toggles = 0;
				err_at_open  = errors;
			end
			if (in_window)
			begin
				if (clk_in && !prev_clk_in)
					in_rises++;
				if (clk_out && !prev_clk_out)
				begin
					out_rises++;
					if (!clk_in)
						lone_rise++;
					if (fault_active)
						act_rises++;
				end
				if (!clk_out && prev_clk_out)
				begin
					if (!clk_in && !prev_clk_in)
						lone_fall++;
					if (fault_active)
						act_falls++;
				end
				if (clk_in && prev_clk_in && din != prev_din)
					high_toggles++;
				// stuck kinds release one cycle after inject_start falls
				if (!inject_start && !fault_active)
				begin
					score_window();
					in_window = 1'b0;
				end
			end
		end
		prev_clk_in  = clk_in;
		prev_clk_out = clk_out;
		prev_din     = din;
		prev_start   = inject_start;
		pass_count  <= passes;
		fail_count  <= fails;
		error_count <= errors;
	end

endmodule

//--- tb/tb_mbus_fault.sv
/*
 * Testbench for the MBus ring clock fault injector.
 * Ring clock period is 40 CLK_FAST cycles, half high; din moves mid low phase.
 * Windows open 5 cycles into a high phase so each fault lands in the next low phase.
 */

module tb_mbus_fault;

	timeunit 1ns;
	timeprecision 100ps;

	import mbus_fault_pkg::*;

	localparam int glitch_delay   = 12;
	localparam int glitch_width   = 4;
	localparam int int_toggles    = 3;
	localparam int int_hold       = 64;
	localparam int ring_period    = 40;
	localparam int open_phase     = 5;
	localparam int data_phase     = 30;
	localparam int window_periods = 3;
	localparam int random_windows = 12;
	localparam int step_limit     = 200;

	logic                   CLK_FAST;
	logic                   RESETn;
	logic                   clk_in;
	logic                   din;
	logic                   inject_start;
	fault_kind_e            fault_kind;
	logic                   clk_out;
	logic                   dout;
	logic                   fault_active;
	logic [count_width-1:0] inject_count;
	int                     pass_count;
	int                     fail_count;
	int                     error_count;

	logic [15:0] lfsr;
	int          phase;
	int          windows;

	mbus_fault_top
	#(
		.glitch_delay (glitch_delay),
		.glitch_width (glitch_width),
		.int_toggles  (int_toggles),
		.int_hold     (int_hold)
	)
	uut
	(
		.CLK_FAST     (CLK_FAST),
		.RESETn       (RESETn),
		.clk_in       (clk_in),
		.din          (din),
		.fault_kind   (fault_kind),
		.inject_start (inject_start),
		.clk_out      (clk_out),
		.dout         (dout),
		.fault_active (fault_active),
		.inject_count (inject_count)
	);

	mbus_fault_checker
	#(
		.int_toggles (int_toggles)
	)
	chk
	(
		.CLK_FAST     (CLK_FAST),
		.RESETn       (RESETn),
		.clk_in       (clk_in),
		.din          (din),
		.fault_kind   (fault_kind),
		.inject_start (inject_start),
		.clk_out      (clk_out),
		.dout         (dout),
		.fault_active (fault_active),
		.inject_count (inject_count),
		.pass_count   (pass_count),
		.fail_count   (fail_count),
		.error_count  (error_count)
	);

	initial
	begin
		CLK_FAST = 1'b0;
		forever
			#2 CLK_FAST = ~CLK_FAST;
	end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b    = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	task automatic take_bits(input int n, output int v);
		logic b;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			take_bit(b);
			v = (v << 1) | b;
		end
	endtask

	task automatic halt_on_timeout(input string what);
		$display("timeout while %s, the DUT did not respond in time", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	// one CLK_FAST cycle of the ring clock generator
	task automatic ring_step();
		logic b;
		@(posedge CLK_FAST);
		phase = (phase == ring_period - 1) ? 0 : phase + 1;
		clk_in <= (phase < ring_period / 2);
		if (phase == data_phase)
		begin
			take_bit(b);
			din <= b;
		end
	endtask

	task automatic wait_phase(input int target);
		int n;
		n = 0;
		ring_step();
		while (phase != target && n < step_limit)
		begin
			ring_step();
			n++;
		end
		if (phase != target)
			halt_on_timeout("waiting for a ring clock phase");
	endtask

	// clock held high, data toggled four times three cycles apart
	task automatic drive_interrupt();
		for (int i = 1; i <= 12; i++)
		begin
			@(posedge CLK_FAST);
			if (i % 3 == 0)
				din <= ~din;
		end
	endtask

	task automatic run_window(input logic [2:0] kind, input logic with_int);
		int   n;
		logic expect_active;
		// after-interrupt kinds only fire once an interrupt was driven
		expect_active = (kind <= 3'd5) && (with_int || (kind != 3'd2 && kind != 3'd3));
		wait_phase(open_phase);
		fault_kind   <= fault_kind_e'(kind);
		inject_start <= 1'b1;
		if (with_int)
		begin
			ring_step();
			drive_interrupt();
		end
		if (expect_active)
		begin
			n = 0;
			while (!fault_active && n < step_limit)
			begin
				ring_step();
				n++;
			end
			if (!fault_active)
				halt_on_timeout("waiting for fault_active");
		end
		for (int p = 0; p < window_periods; p++)
			wait_phase(open_phase);
		inject_start <= 1'b0;
		windows++;
		n = 0;
		while ((pass_count + fail_count) < windows && n < step_limit)
		begin
			ring_step();
			n++;
		end
		if ((pass_count + fail_count) < windows)
			halt_on_timeout("waiting for the end of a window");
	endtask

	initial
	begin
		int kind_val;
		logic int_bit;
		RESETn       = 1'b0;
		clk_in       = 1'b0;
		din          = 1'b0;
		inject_start = 1'b0;
		fault_kind   = GLITCH;
		lfsr         = 16'd55187;
		phase        = ring_period - 1;
		windows      = 0;
		repeat (10) @(posedge CLK_FAST);
		RESETn <= 1'b1;
		// pass-through only
		wait_phase(open_phase);
		wait_phase(open_phase);
		run_window(GLITCH, 1'b0);
		run_window(MISS_EDGE, 1'b0);
		run_window(GLITCH_AFTER_INT, 1'b0);
		run_window(MISS_AFTER_INT, 1'b0);
		run_window(GLITCH_AFTER_INT, 1'b1);
		run_window(MISS_AFTER_INT, 1'b1);
		run_window(STUCK_LOW, 1'b0);
		run_window(STUCK_HIGH, 1'b0);
		// random kinds, codes 6 and 7 included
		for (int i = 0; i < random_windows; i++)
		begin
			take_bits(3, kind_val);
			take_bit(int_bit);
			run_window(kind_val[2:0], int_bit);
		end
		wait_phase(open_phase);
		$display("tests %0d: %0d passed, %0d failed, %0d errors", windows, pass_count,
			fail_count, error_count);
		if (fail_count == 0 && error_count == 0 && pass_count == windows)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- flist.f
src/mbus_fault_pkg.sv
src/mbus_line_sync.sv
src/mbus_int_detect.sv
src/mbus_fault_fsm.sv
src/mbus_clk_gate.sv
src/mbus_fault_top.sv
tb/mbus_fault_checker.sv
tb/tb_mbus_fault.sv
